// File: build.f
+incdir+.
fetch_pkg.sv
ex_branch_if.sv
host_bus_if.sv
branch_resolver.sv
instr_cache.sv
fetch_stage.sv
tb_host_mem.sv
tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch stage testbench with verilator and run it
# exit status is 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_fetch -o sim_fetch
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_fetch)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
echo "pass line not found in simulation output"
exit 1

// File: tb_fetch.sv
// ------------------------------
// fetch stage testbench
// table driven pc and instr checks
// against a random latency host model
// ------------------------------

`timescale 1ns/1ps

`include "fetch_config.svh"

module tb_fetch
	import fetch_pkg::*;
();

	localparam logic [31:0] WORD_PATTERN = 32'h5a3c_96e1;
	localparam logic [31:0] CPU_WORD = 32'h00a0_0093;
	localparam logic [31:0] INT_WORD = 32'h3020_0073;
	localparam logic [31:0] RESTORE_PC = 32'h0600_2100;
	localparam logic [31:0] LINE_MASK = ~32'(`FETCH_LINE_BITS / 8 - 1);
	localparam int DONE_TIMEOUT = 100;

	// expected next pc
	localparam logic [1:0] PC_TGT = 2'd0;
	localparam logic [1:0] PC_PLUS4 = 2'd1;
	localparam logic [1:0] PC_HOLD = 2'd2;
	localparam logic [1:0] PC_REST = 2'd3;

	// expected instr source
	localparam logic [1:0] SRC_CACHE = 2'd0;
	localparam logic [1:0] SRC_CPU = 2'd1;
	localparam logic [1:0] SRC_INT = 2'd2;

	localparam logic [2:0] GRP_SEQ = 3'd2;
	localparam logic [2:0] GRP_BR = 3'd3;
	localparam logic [2:0] GRP_STALL = 3'd4;
	localparam logic [2:0] GRP_INJ = 3'd5;
	localparam logic [2:0] GRP_REST = 3'd6;

	typedef struct packed {
		logic [2:0]  grp;
		logic        stall;
		logic        flush;
		logic        restore;
		logic        use_cpu;
		logic        use_int;
		logic        branch;
		logic        jump;
		logic [4:0]  alu_op;
		logic [1:0]  flags;
		logic [31:0] target;
		logic [1:0]  pc_kind;
		logic [1:0]  src;
	} entry_t;

	logic                        clk;
	logic                        rst_n;
	logic                        stall;
	logic                        flush;
	logic                        restore;
	logic [31:0]                 pc_before_int;
	logic                        use_cpu_injection;
	logic [31:0]                 cpu_injection;
	logic                        use_int_instr;
	logic [31:0]                 int_instr;
	logic                        ex_branch;
	logic                        ex_jump;
	logic [4:0]                  ex_alu_op;
	logic [31:0]                 ex_target;
	logic [1:0]                  ex_flags;
	logic [`FETCH_LINE_BITS-1:0] host_data;
	logic                        host_rd_valid;
	logic [31:0]                 host_addr;
	logic [1:0]                  host_op;
	logic [31:0]                 instr;
	logic                        done;
	logic [31:0]                 current_pc;
	int                          read_count;
	logic [31:0]                 last_addr;

	entry_t     table_q[$];
	logic [2:0] cur_grp;
	int         pass_count;
	int         fail_count;
	int         entry_errors;
	bit         timed_out;

	fetch_stage fetch_stage_i (.*);

	tb_host_mem #(.PATTERN(WORD_PATTERN)) host_mem_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr       (host_addr),
		.op         (host_op),
		.data       (host_data),
		.rd_valid   (host_rd_valid),
		.read_count (read_count),
		.last_addr  (last_addr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ctl is {stall, flush, restore, use_cpu, use_int}, br is {branch, jump}
	task automatic add_row(input logic [4:0] ctl, input logic [1:0] br,
		input logic [4:0] alu_op, input logic [1:0] flags, input logic [31:0] target,
		input logic [1:0] pc_kind, input logic [1:0] src);
		entry_t e;
		e.grp = cur_grp;
		{e.stall, e.flush, e.restore, e.use_cpu, e.use_int} = ctl;
		{e.branch, e.jump} = br;
		e.alu_op  = alu_op;
		e.flags   = flags;
		e.target  = target;
		e.pc_kind = pc_kind;
		e.src     = src;
		table_q.push_back(e);
	endtask

	task automatic build_table();
		// straight run, crosses from line 0x0600_2000 into 0x0600_2040
		cur_grp = GRP_SEQ;
		for (int k = 0; k < 17; k++) begin
			add_row(5'b00000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		end
		// branches, flags n z
		cur_grp = GRP_BR;
		add_row(5'b00000, 2'b10, 5'h00, 2'b01, 32'h0600_2400, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h14, 2'b10, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h01, 2'b00, 32'h0600_2804, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h09, 2'b11, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h02, 2'b10, 32'h0600_2a3c, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h06, 2'b01, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h03, 2'b01, 32'h0600_2c40, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b10, 5'h1f, 2'b10, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		// jumps, code 3 falls through
		add_row(5'b00000, 2'b01, 5'h00, 2'b00, 32'h0600_3000, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b01, 5'h01, 2'b11, 32'h0600_3104, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b01, 5'h02, 2'b00, 32'h0600_2000, PC_TGT, SRC_CACHE);
		add_row(5'b00000, 2'b01, 5'h03, 2'b01, 32'h0600_3200, PC_PLUS4, SRC_CACHE);
		// stall and flush
		cur_grp = GRP_STALL;
		add_row(5'b00000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b01000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b10000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_HOLD, SRC_CACHE);
		add_row(5'b11000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b10000, 2'b01, 5'h00, 2'b00, 32'h0600_3000, PC_HOLD, SRC_CACHE);
		// injection sources
		cur_grp = GRP_INJ;
		add_row(5'b00011, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_HOLD, SRC_CPU);
		add_row(5'b00001, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_HOLD, SRC_INT);
		add_row(5'b00010, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_HOLD, SRC_CPU);
		// restore beats stall, injection and a taken jump
		cur_grp = GRP_REST;
		add_row(5'b10100, 2'b01, 5'h00, 2'b00, 32'h0600_3000, PC_REST, SRC_CACHE);
		add_row(5'b00000, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_PLUS4, SRC_CACHE);
		add_row(5'b01110, 2'b00, 5'h00, 2'b00, 32'h0600_5000, PC_REST, SRC_CPU);
	endtask

	function automatic string grp_name(input logic [2:0] grp);
		case (grp)
			GRP_SEQ:   return "sequential";
			GRP_BR:    return "branch";
			GRP_STALL: return "stall/flush";
			GRP_INJ:   return "injection";
			default:   return "restore";
		endcase
	endfunction

	// idle pipeline, stall held so the pc waits on the cache
	task automatic drive_idle();
		stall             = 1'b1;
		flush             = 1'b0;
		restore           = 1'b0;
		use_cpu_injection = 1'b0;
		use_int_instr     = 1'b0;
		ex_branch         = 1'b0;
		ex_jump           = 1'b0;
		ex_alu_op         = 5'h00;
		ex_flags          = 2'b00;
		ex_target         = 32'h0;
	endtask

	task automatic apply_entry(input entry_t e);
		{stall, flush, restore} = {e.stall, e.flush, e.restore};
		{use_cpu_injection, use_int_instr} = {e.use_cpu, e.use_int};
		{ex_branch, ex_jump} = {e.branch, e.jump};
		ex_alu_op = e.alu_op;
		ex_flags  = e.flags;
		ex_target = e.target;
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] got,
		input logic [31:0] exp);
		$display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, sig, got, exp);
		entry_errors++;
	endtask

	task automatic close_test(input int num, input string what);
		if (entry_errors == 0) begin
			pass_count++;
			$display("test %0d %s: ok", num, what);
		end else begin
			fail_count++;
			$display("test %0d %s: %0d errors", num, what, entry_errors);
		end
	endtask

	// polls done on falling edges
	task automatic wait_for_done(output bit ok);
		int n;
		n = 0;
		while (done !== 1'b1 && n < DONE_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		ok = (done === 1'b1);
	endtask

	initial begin
		entry_t      e;
		bit          ok;
		int          reads_before;
		int          reads;
		logic [31:0] model_pc;
		logic [31:0] pc_now;
		logic [31:0] line_now;
		logic [31:0] prev_line;
		logic [31:0] exp_pc;
		logic [31:0] exp_instr;
		rst_n         = 1'b0;
		pc_before_int = RESTORE_PC;
		cpu_injection = CPU_WORD;
		int_instr     = INT_WORD;
		drive_idle();
		pass_count = 0;
		fail_count = 0;
		timed_out  = 1'b0;
		build_table();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		#1;
		// state right after reset, before any edge
		entry_errors = 0;
		if (current_pc !== `FETCH_RESET_PC) begin
			report_mismatch("current_pc", current_pc, `FETCH_RESET_PC);
		end
		if (host_op !== host_idle) report_mismatch("host_op", 32'(host_op), 32'(host_idle));
		if (done !== 1'b0) report_mismatch("done", 32'(done), 32'h0);
		close_test(1, "reset");
		@(negedge clk);
		prev_line = 32'hffff_ffff;
		// fetch address tracked by the testbench
		model_pc = `FETCH_RESET_PC;
		for (int i = 0; i < table_q.size() && !timed_out; i++) begin
			e = table_q[i];
			entry_errors = 0;
			reads_before = read_count;
			wait_for_done(ok);
			if (!ok) begin
				$display("done never rose within %0d cycles at pc 0x%h", DONE_TIMEOUT,
					current_pc);
				timed_out = 1'b1;
				entry_errors++;
			end else begin
				// pc must not have moved while stall was held
				pc_now = model_pc;
				if (current_pc !== pc_now) report_mismatch("current_pc", current_pc, pc_now);
				line_now = pc_now & LINE_MASK;
				reads    = read_count - reads_before;
				// host traffic for this fetch
				if (line_now == prev_line && reads != 0) begin
					$display("host read issued while pc stayed in line 0x%h", line_now);
					entry_errors++;
				end
				if (reads > 1) begin
					$display("%0d host reads issued for line 0x%h", reads, line_now);
					entry_errors++;
				end
				if (e.grp == GRP_SEQ && line_now != prev_line && reads != 1) begin
					$display("new line 0x%h fetched without one host read", line_now);
					entry_errors++;
				end
				if (reads == 1 && last_addr !== line_now) begin
					report_mismatch("host_addr", last_addr, line_now);
				end
				prev_line = line_now;
				apply_entry(e);
				#1;
				case (e.src)
					SRC_CPU: exp_instr = CPU_WORD;
					SRC_INT: exp_instr = INT_WORD;
					default: exp_instr = pc_now ^ WORD_PATTERN;
				endcase
				if (instr !== exp_instr) report_mismatch("instr", instr, exp_instr);
				case (e.pc_kind)
					PC_TGT:   exp_pc = e.target;
					PC_HOLD:  exp_pc = pc_now;
					PC_REST:  exp_pc = RESTORE_PC;
					default:  exp_pc = pc_now + 32'd4;
				endcase
				@(posedge clk);
				@(negedge clk);
				if (current_pc !== exp_pc) report_mismatch("current_pc", current_pc, exp_pc);
				model_pc = exp_pc;
				drive_idle();
			end
			close_test(i + 2, grp_name(e.grp));
		end
		$display("tests run: %0d, passed: %0d, failed: %0d", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0 && !timed_out) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: tb_host_mem.sv
// ------------------------------
// host memory model
// answers line reads after a random delay
// ------------------------------

`timescale 1ns/1ps

`include "fetch_config.svh"

module tb_host_mem
	import fetch_pkg::*;
#(
	parameter logic [31:0] PATTERN = 32'h0
) (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [31:0]                 addr,
	input  logic [1:0]                  op,
	output logic [`FETCH_LINE_BITS-1:0] data,
	output logic                        rd_valid,
	output int                          read_count,
	output logic [31:0]                 last_addr
);

	localparam int LINE_WORDS = `FETCH_LINE_BITS / 32;

	integer seed = 61101;
	integer r;
	int     wait_left;
	logic   busy;

	// word at byte address a holds a ^ PATTERN
	function automatic logic [`FETCH_LINE_BITS-1:0] line_at(input logic [31:0] base);
		logic [`FETCH_LINE_BITS-1:0] line;
		line = '0;
		for (int w = 0; w < LINE_WORDS; w++) begin
			line[w*32 +: 32] = (base + 32'(w * 4)) ^ PATTERN;
		end
		return line;
	endfunction

	// outputs move on the falling edge
	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data       <= '0;
			rd_valid   <= 1'b0;
			busy       <= 1'b0;
			wait_left  <= 0;
			read_count <= 0;
			last_addr  <= '0;
		end else if (rd_valid) begin
			// line taken at the last rising edge
			rd_valid <= 1'b0;
			busy     <= 1'b0;
		end else if (busy) begin
			if (wait_left <= 1) begin
				data     <= line_at(last_addr);
				rd_valid <= 1'b1;
			end else begin
				wait_left <= wait_left - 1;
			end
		end else if (op == host_read) begin
			// new request, 1 to 6 cycles of latency
			r          = $random(seed);
			wait_left  <= 1 + ((r & 32'h7fff_ffff) % 6);
			busy       <= 1'b1;
			read_count <= read_count + 1;
			last_addr  <= addr;
		end
	end

endmodule

// File: fetch_stage.sv
// ------------------------------
// fetch stage
// pc register, next-pc select, icache
// and the instruction source mux
// ------------------------------

`timescale 1ns/1ps

`include "fetch_config.svh"

module fetch_stage
	import fetch_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,

	// pipeline control
	input  logic                        stall,
	input  logic                        flush,
	input  logic                        restore,
	input  logic [31:0]                 pc_before_int,

	// injected instructions
	input  logic                        use_cpu_injection,
	input  logic [31:0]                 cpu_injection,
	input  logic                        use_int_instr,
	input  logic [31:0]                 int_instr,

	// ex/mem branch info
	input  logic                        ex_branch,
	input  logic                        ex_jump,
	input  logic [4:0]                  ex_alu_op,
	input  logic [31:0]                 ex_target,
	input  logic [1:0]                  ex_flags,

	// host memory controller
	input  logic [`FETCH_LINE_BITS-1:0] host_data,
	input  logic                        host_rd_valid,
	output logic [31:0]                 host_addr,
	output logic [1:0]                  host_op,

	// to decode
	output logic [31:0]                 instr,
	output logic                        done,
	output logic [31:0]                 current_pc
);

	ex_branch_if ex_bus ();
	host_bus_if  host_bus ();

	logic [31:0] pc;
	logic [31:0] pc_next;
	logic [31:0] pc_plus4;
	logic [31:0] cache_word;
	logic        taken;
	logic        hold;

	// plain ports into the branch bundle
	assign ex_bus.branch = ex_branch;
	assign ex_bus.jump   = ex_jump;
	assign ex_bus.alu_op = ex_alu_op;
	assign ex_bus.flags  = flags_t'(ex_flags);
	assign ex_bus.target = ex_target;

	// host bundle out to the pins
	assign host_bus.data     = host_data;
	assign host_bus.rd_valid = host_rd_valid;
	assign host_addr         = host_bus.addr;
	assign host_op           = host_bus.op;

	branch_resolver branch_resolver_i (
		.ex    (ex_bus),
		.taken (taken)
	);

	instr_cache instr_cache_i (
		.clk   (clk),
		.rst_n (rst_n),
		.addr  (pc),
		.done  (done),
		.word  (cache_word),
		.host  (host_bus)
	);

	assign pc_plus4 = pc + 32'd4;

	// flush overrides stall since a flush means pc must move
	// any injection keeps the pc where it is
	assign hold = (stall && !flush) || use_cpu_injection || use_int_instr;

	// restore > hold > taken > sequential
	always_comb begin
		if (restore) begin
			pc_next = pc_before_int;
		end else if (hold) begin
			pc_next = pc;
		end else if (taken) begin
			pc_next = ex_bus.target;
		end else begin
			pc_next = pc_plus4;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `FETCH_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// cpu injection wins over the interrupt controller
	assign instr = use_cpu_injection ? cpu_injection :
		(use_int_instr ? int_instr : cache_word);

	assign current_pc = pc;

endmodule

// File: instr_cache.sv
// ------------------------------
// instruction cache
// direct-mapped and read-only
// fills whole lines from the host controller
// ------------------------------

`timescale 1ns/1ps

`include "fetch_config.svh"

module instr_cache
	import fetch_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] addr,
	output logic        done,
	output logic [31:0] word,
	host_bus_if.cache   host
);

	// address split
	// | tag | index | word | byte |
	localparam int LINE_BITS = `FETCH_LINE_BITS;
	localparam int NUM_LINES = `FETCH_CACHE_LINES;
	localparam int LINE_WORDS = LINE_BITS / 32;
	localparam int OFS_BITS = $clog2(LINE_BITS / 8);
	localparam int WORD_BITS = $clog2(LINE_WORDS);
	localparam int IDX_BITS = $clog2(NUM_LINES);
	localparam int TAG_BITS = 32 - OFS_BITS - IDX_BITS;

	typedef enum logic {
		st_lookup = 1'b0,
		st_fill   = 1'b1
	} state_t;

	state_t state;
	state_t state_nxt;

	logic [TAG_BITS-1:0]  tag;
	logic [IDX_BITS-1:0]  idx;
	logic [WORD_BITS-1:0] word_sel;

	// line storage
	logic [LINE_BITS-1:0] lines [NUM_LINES];
	logic [TAG_BITS-1:0]  tags [NUM_LINES];
	logic [NUM_LINES-1:0] valid;

	// line being filled
	// latched so the request holds even if addr moves
	logic [TAG_BITS-1:0] fill_tag;
	logic [IDX_BITS-1:0] fill_idx;

	logic                 hit;
	logic [LINE_BITS-1:0] line_rd;

	assign tag      = addr[31 -: TAG_BITS];
	assign idx      = addr[OFS_BITS +: IDX_BITS];
	assign word_sel = addr[2 +: WORD_BITS];

	// tag compare on the addressed line
	assign hit = valid[idx] && (tags[idx] == tag);

	// done only from lookup
	// during a fill the old line contents are stale for this addr
	assign done = (state == st_lookup) && hit;

	// word 0 of the line sits in the low 32 bits
	assign line_rd = lines[idx];
	assign word    = line_rd[word_sel * 32 +: 32];

	// host request is a level for the whole fill
	assign host.op   = (state == st_fill) ? host_read : host_idle;
	assign host.addr = {fill_tag, fill_idx, {OFS_BITS{1'b0}}};

	// fill machine
	always_comb begin
		state_nxt = state;
		case (state)
			st_lookup: begin
				if (!hit) begin
					state_nxt = st_fill;
				end
			end
			st_fill: begin
				// back to lookup once the line lands
				if (host.rd_valid) begin
					state_nxt = st_lookup;
				end
			end
			default: state_nxt = st_lookup;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_lookup;
		end else begin
			state <= state_nxt;
		end
	end

	// valid bits cleared on reset
	// nothing hits until the first fill
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (state == st_fill && host.rd_valid) begin
			valid[fill_idx] <= 1'b1;
		end
	end

	// capture the missing line address on the way into fill
	always_ff @(posedge clk) begin
		if (state == st_lookup && !hit) begin
			fill_tag <= tag;
			fill_idx <= idx;
		end
	end

	// line data and tag written with rd_valid
	always_ff @(posedge clk) begin
		if (state == st_fill && host.rd_valid) begin
			lines[fill_idx] <= host.data;
			tags[fill_idx]  <= fill_tag;
		end
	end

endmodule

// File: branch_resolver.sv
// ------------------------------
// branch resolver
// decides if the ex/mem branch or jump is taken
// ------------------------------

`timescale 1ns/1ps

module branch_resolver
	import fetch_pkg::*;
(
	ex_branch_if.resolver ex,
	output logic          taken
);

	branch_cond_t cond;
	flags_t       fl;
	logic         cond_true;

	// only the low two bits of alu_op select the condition
	assign cond = branch_cond_t'(ex.alu_op[1:0]);
	assign fl   = ex.flags;

	// flag test for conditional branches
	always_comb begin
		case (cond)
			cond_eq: cond_true = fl.z;
			cond_ne: cond_true = ~fl.z;
			cond_lt: cond_true = fl.n;
			cond_ge: cond_true = ~fl.n;
			default: cond_true = 1'b0;
		endcase
	end

	always_comb begin
		taken = 1'b0;
		if (ex.branch && !ex.jump) begin
			// branch without jump follows the flags
			taken = cond_true;
		end else if (ex.jump) begin
			// jumps ignore flags
			// code 3 is not a jump target form
			case (cond)
				cond_eq: taken = 1'b1;
				cond_ne: taken = 1'b1;
				cond_lt: taken = 1'b1;
				default: taken = 1'b0;
			endcase
		end
		// neither set means fall through
	end

endmodule

// File: host_bus_if.sv
// ------------------------------
// host line fill bus
// cache side of the host memory controller
// ------------------------------

`timescale 1ns/1ps

`include "fetch_config.svh"

interface host_bus_if import fetch_pkg::*; ();

	// line-aligned read address
	logic [31:0]                 addr;
	// idle or read
	host_op_t                    op;
	// whole line, valid with rd_valid
	logic [`FETCH_LINE_BITS-1:0] data;
	// one cycle pulse per finished read
	logic                        rd_valid;

	// cache requests and takes the line
	modport cache (output addr, op, input data, rd_valid);

	// tied to the top-level host ports
	modport host (input addr, op, output data, rd_valid);

endinterface

// File: ex_branch_if.sv
// ------------------------------
// ex/mem branch bundle
// branch info from the pipeline into the resolver
// ------------------------------

`timescale 1ns/1ps

interface ex_branch_if import fetch_pkg::*; ();

	// conditional branch in ex/mem
	logic        branch;
	// unconditional jump in ex/mem
	logic        jump;
	// low two bits pick the condition
	logic [4:0]  alu_op;
	// n and z from the alu
	flags_t      flags;
	// branch or jump destination
	logic [31:0] target;

	// top level fills the bundle
	modport stage (output branch, jump, alu_op, flags, target);

	// resolver only looks
	modport resolver (input branch, jump, alu_op, flags, target);

endinterface

// File: fetch_pkg.sv
// ------------------------------
// fetch package
// shared types for the fetch stage
// ------------------------------

package fetch_pkg;

	// host memory controller operation
	// the instruction cache only reads
	typedef enum logic [1:0] {
		host_idle  = 2'd0,
		host_read  = 2'd1,
		host_write = 2'd2
	} host_op_t;

	// branch condition from alu_op[1:0]
	// eq and ne look at z
	// lt and ge look at n
	typedef enum logic [1:0] {
		cond_eq = 2'd0,
		cond_ne = 2'd1,
		cond_lt = 2'd2,
		cond_ge = 2'd3
	} branch_cond_t;

	// condition flags from the alu
	// n is bit 1, z is bit 0
	typedef struct packed {
		// negative
		logic n;
		// zero
		logic z;
	} flags_t;

endpackage

// File: fetch_config.svh
// ------------------------------
// fetch config
// reset pc, line width and cache depth
// for the instruction fetch stage
// ------------------------------

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// start of instruction memory
// pc comes out of reset here
`define FETCH_RESET_PC 32'h0600_2000

// one cache line is one host transfer
// 512 bits gives 16 words per line
`define FETCH_LINE_BITS 512

// number of direct-mapped lines
// must be a power of two
`define FETCH_CACHE_LINES 16

`endif
